// ==== src/pss_sig_pkg.sv ====
package pss_sig_pkg;

    // ----------------------------------------
    // sample and metric widths
    // ----------------------------------------

    localparam int SAMPLE_DW = 8;
    localparam int PSS_LEN   = 16;
    localparam int NUM_SEQ   = 3;

    // 2 * 16 * 128 = 4096 is the largest metric, so 14 bits leave headroom
    localparam int METRIC_DW = 14;

    // a per-component sum grows by log2(PSS_LEN) bits, plus one so +2048 fits
    localparam int ACC_DW = SAMPLE_DW + $clog2(PSS_LEN) + 1;

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef struct packed {
        logic signed [SAMPLE_DW-1:0] re;
        logic signed [SAMPLE_DW-1:0] im;
    } iq_sample_t;

    // element 0 holds the newest sample, element PSS_LEN-1 the oldest
    typedef iq_sample_t [PSS_LEN-1:0] sample_window_t;

    // bit i is tap i, a 1 stands for +1 and a 0 for -1
    // tap 0 is transmitted first, so it lines up with the oldest window element
    typedef logic [PSS_LEN-1:0] pss_taps_t;

    typedef logic [METRIC_DW-1:0] metric_t;

    typedef logic signed [ACC_DW-1:0] acc_t;

    // ----------------------------------------
    // local sequences, one per N_id_2
    // ----------------------------------------

    // pairwise zero-lag cross-correlation of these is -2, -2 and -4
    localparam pss_taps_t PSS_TAPS [NUM_SEQ] = '{
        16'h1ACF,
        16'h63A5,
        16'hC659
    };

endpackage

// ==== src/pss_ctrl_pkg.sv ====
package pss_ctrl_pkg;

    // ----------------------------------------
    // detection control
    // ----------------------------------------

    // the encoding 3 is not named and behaves like PAUSE
    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } detect_mode_t;

    typedef logic [1:0] nid2_t;

    // a lane peaks on the first metric at or above this level
    localparam pss_sig_pkg::metric_t PEAK_THRESHOLD = pss_sig_pkg::metric_t'(1200);

    // ----------------------------------------
    // detection result
    // ----------------------------------------

    // valid pulses for one cycle, nid2 holds until the next detection
    typedef struct packed {
        logic  valid;
        nid2_t nid2;
    } nid2_result_t;

endpackage

// ==== src/pss_sample_window.sv ====
`timescale 1ns/1ps

module pss_sample_window (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  pss_sig_pkg::iq_sample_t     sample_i,
    input  logic                        sample_valid_i,
    input  logic                        window_en_i,
    output pss_sig_pkg::sample_window_t window_o,
    output logic                        window_valid_o
);

    import pss_sig_pkg::*;

    iq_sample_t     sample_q;
    logic           accept_q;
    sample_window_t window_q;
    logic           window_valid_q;

    // ----------------------------------------
    // input register
    // ----------------------------------------

    // the sample is captured on the accepting edge and shifted in one edge later
    always_ff @(posedge clk_i) begin
        if (sample_valid_i && window_en_i) begin
            sample_q <= sample_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            accept_q <= 1'b0;
        end else begin
            accept_q <= sample_valid_i && window_en_i;
        end
    end

    // ----------------------------------------
    // shared delay line
    // ----------------------------------------

    // one copy feeds all three lanes, the newest sample enters at element 0
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            window_q       <= '0;
            window_valid_q <= 1'b0;
        end else begin
            window_valid_q <= accept_q;
            if (accept_q) begin
                window_q <= {window_q[PSS_LEN-2:0], sample_q};
            end
        end
    end

    assign window_o       = window_q;
    assign window_valid_o = window_valid_q;

    // every window update goes back to an accept made while the front end was enabled
    a_valid_needs_enable : assert property (@(posedge clk_i) disable iff (!reset_ni)
        window_valid_o |-> $past(window_en_i, 2));

endmodule

// ==== src/pss_correlator_lane.sv ====
`timescale 1ns/1ps

module pss_correlator_lane #(
    parameter int LANE = 0
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  pss_sig_pkg::sample_window_t window_i,
    input  logic                        window_valid_i,
    output pss_sig_pkg::metric_t        metric_o,
    output logic                        metric_valid_o,
    output logic                        peak_o
);

    import pss_sig_pkg::*;
    import pss_ctrl_pkg::*;

    acc_t              sum_re;
    acc_t              sum_im;
    logic [ACC_DW-1:0] abs_re;
    logic [ACC_DW-1:0] abs_im;
    metric_t           metric_q;
    logic              metric_valid_q;
    metric_t           prev_metric_q;
    logic              peak_q;

    // ----------------------------------------
    // correlation with the local sequence
    // ----------------------------------------

    // taps are +-1, so each product reduces to an add or a subtract
    // tap 0 was sent first and sits at the oldest end of the window
    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int i = 0; i < PSS_LEN; i++) begin
            if (PSS_TAPS[LANE][i]) begin
                sum_re = sum_re + acc_t'(window_i[PSS_LEN-1-i].re);
                sum_im = sum_im + acc_t'(window_i[PSS_LEN-1-i].im);
            end else begin
                sum_re = sum_re - acc_t'(window_i[PSS_LEN-1-i].re);
                sum_im = sum_im - acc_t'(window_i[PSS_LEN-1-i].im);
            end
        end
    end

    // the most negative sum is -2048, so the magnitude never wraps
    always_comb begin
        abs_re = sum_re[ACC_DW-1] ? -sum_re : sum_re;
        abs_im = sum_im[ACC_DW-1] ? -sum_im : sum_im;
    end

    // ----------------------------------------
    // metric register
    // ----------------------------------------

    // |re| + |im| stands in for the true magnitude
    always_ff @(posedge clk_i) begin
        if (window_valid_i) begin
            metric_q <= metric_t'(abs_re) + metric_t'(abs_im);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            metric_valid_q <= 1'b0;
        end else begin
            metric_valid_q <= window_valid_i;
        end
    end

    // ----------------------------------------
    // rising threshold crossing
    // ----------------------------------------

    // only the first metric above threshold fires, a plateau gives one pulse
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            prev_metric_q <= '0;
            peak_q        <= 1'b0;
        end else begin
            peak_q <= 1'b0;
            if (metric_valid_q) begin
                prev_metric_q <= metric_q;
                peak_q        <= (metric_q >= PEAK_THRESHOLD) &&
                                 (prev_metric_q < PEAK_THRESHOLD);
            end
        end
    end

    assign metric_o       = metric_q;
    assign metric_valid_o = metric_valid_q;
    assign peak_o         = peak_q;

    // a peak is always the consequence of a fresh metric one cycle earlier
    a_peak_after_metric : assert property (@(posedge clk_i) disable iff (!reset_ni)
        peak_o |-> $past(metric_valid_o));

endmodule

// ==== src/pss_nid2_decider.sv ====
`timescale 1ns/1ps

module pss_nid2_decider (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic [pss_sig_pkg::NUM_SEQ-1:0]  peaks_i,
    input  pss_ctrl_pkg::detect_mode_t       mode_i,
    input  pss_ctrl_pkg::nid2_t              requested_nid2_i,
    output logic                             window_en_o,
    output pss_ctrl_pkg::nid2_result_t       result_o
);

    import pss_sig_pkg::*;
    import pss_ctrl_pkg::*;

    logic [1:0]   peak_cnt;
    nid2_t        peak_idx;
    logic         single_peak;
    logic         req_hit;
    nid2_result_t result_q;
    logic         window_en_q;

    // ----------------------------------------
    // peak vector check
    // ----------------------------------------

    // count the lanes that fired and remember which one it was
    always_comb begin
        peak_cnt = '0;
        peak_idx = '0;
        for (int k = 0; k < NUM_SEQ; k++) begin
            if (peaks_i[k]) begin
                peak_cnt = peak_cnt + 2'd1;
                peak_idx = nid2_t'(k);
            end
        end
    end

    // two lanes at once is ambiguous and is dropped
    assign single_peak = (peak_cnt == 2'd1);

    // a requested value of 3 has no lane and never matches
    assign req_hit = single_peak && (peak_idx == requested_nid2_i);

    // ----------------------------------------
    // mode FSM and result register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            result_q    <= '0;
            window_en_q <= 1'b0;
        end else begin
            result_q.valid <= 1'b0;
            case (mode_i)
                SEARCH: begin
                    window_en_q <= 1'b1;
                    if (single_peak) begin
                        result_q.valid <= 1'b1;
                        result_q.nid2  <= peak_idx;
                    end
                end
                FIND: begin
                    window_en_q <= 1'b1;
                    if (req_hit) begin
                        result_q.valid <= 1'b1;
                        result_q.nid2  <= requested_nid2_i;
                    end
                end
                default: begin
                    // pause stops the front end from accepting new samples
                    window_en_q <= 1'b0;
                end
            endcase
        end
    end

    assign window_en_o = window_en_q;
    assign result_o    = result_q;

    // no detection may leave the decider right after a paused cycle
    a_no_result_after_pause : assert property (@(posedge clk_i) disable iff (!reset_ni)
        result_o.valid |-> ($past(mode_i) inside {SEARCH, FIND}));

endmodule

// ==== src/pss_detector.sv ====
`timescale 1ns/1ps

module pss_detector (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  pss_sig_pkg::iq_sample_t    sample_i,
    input  logic                       sample_valid_i,
    input  pss_ctrl_pkg::detect_mode_t mode_i,
    input  pss_ctrl_pkg::nid2_t        requested_nid2_i,
    output pss_ctrl_pkg::nid2_result_t result_o
);

    import pss_sig_pkg::*;

    sample_window_t     window;
    logic               window_valid;
    logic               window_en;
    logic [NUM_SEQ-1:0] peaks;

    // ----------------------------------------
    // shared sample window
    // ----------------------------------------

    pss_sample_window i_sample_window (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .window_en_i    (window_en),
        .window_o       (window),
        .window_valid_o (window_valid)
    );

    // ----------------------------------------
    // one correlator lane per N_id_2
    // ----------------------------------------

    // the metrics stay inside the lanes, only the peak flags go on
    for (genvar n = 0; n < NUM_SEQ; n++) begin : g_lane
        pss_correlator_lane #(
            .LANE (n)
        ) i_lane (
            .clk_i          (clk_i),
            .reset_ni       (reset_ni),
            .window_i       (window),
            .window_valid_i (window_valid),
            .metric_o       (),
            .metric_valid_o (),
            .peak_o         (peaks[n])
        );
    end

    pss_nid2_decider i_nid2_decider (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .peaks_i          (peaks),
        .mode_i           (mode_i),
        .requested_nid2_i (requested_nid2_i),
        .window_en_o      (window_en),
        .result_o         (result_o)
    );

endmodule

// ==== test/tb_pss_model.svh ====
`ifndef TB_PSS_MODEL_SVH
`define TB_PSS_MODEL_SVH

// ----------------------------------------
// stimulus rows
// ----------------------------------------

// a seq of 3 embeds no sequence
// an exp_hits of 3 leaves the pulse count to the cycle model alone
typedef struct packed {
    detect_mode_t mode;
    nid2_t        req;
    logic [1:0]   seq;
    logic [7:0]   amp;
    logic [7:0]   noise;
    logic         rand_gap;
    logic [1:0]   exp_hits;
    nid2_t        exp_nid2;
} stim_row_t;

// ----------------------------------------
// pseudo random source
// ----------------------------------------

logic [31:0] lfsr_state;

// fibonacci form of x^32 + x^22 + x^2 + x + 1, one step for each bit taken
function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits       = {bits[30:0], fb};
    end
    return bits;
endfunction

// uniform noise in [-amp_n, amp_n)
function automatic int noise_val(int amp_n);
    logic [31:0]       bits;
    logic signed [7:0] r;
    bits = lfsr_bits(8);
    r    = bits[7:0];
    return (int'(r) * amp_n) / 128;
endfunction

// ----------------------------------------
// reference detector
// ----------------------------------------

// tap 0 went in first, so it now sits at the oldest window element
function automatic int corr_metric(sample_window_t w, int lane);
    int sum_re;
    int sum_im;
    int tap_sign;
    sum_re = 0;
    sum_im = 0;
    for (int i = 0; i < PSS_LEN; i++) begin
        tap_sign = PSS_TAPS[lane][i] ? 1 : -1;
        sum_re   = sum_re + tap_sign * int'(w[PSS_LEN-1-i].re);
        sum_im   = sum_im + tap_sign * int'(w[PSS_LEN-1-i].im);
    end
    if (sum_re < 0) begin
        sum_re = -sum_re;
    end
    if (sum_im < 0) begin
        sum_im = -sum_im;
    end
    return sum_re + sum_im;
endfunction

sample_window_t     model_win;
logic               model_en;
int                 prev_metric [NUM_SEQ];
logic [NUM_SEQ-1:0] peak_pipe [4];
nid2_result_t       exp_result;

// one call per rising clock edge, with the inputs that edge saw
function automatic void model_edge(logic rst_n, iq_sample_t s, logic v,
                                   detect_mode_t mode, nid2_t req);
    logic [NUM_SEQ-1:0] peaks_new;
    logic [NUM_SEQ-1:0] peaks_dec;
    int                 metric;
    int                 hits;
    nid2_t              idx;
    peaks_new = '0;
    hits      = 0;
    idx       = '0;
    if (!rst_n) begin
        model_win  = '0;
        model_en   = 1'b0;
        exp_result = '0;
        for (int k = 0; k < NUM_SEQ; k++) begin
            prev_metric[k] = 0;
        end
        for (int j = 0; j < 4; j++) begin
            peak_pipe[j] = '0;
        end
    end else begin
        // peaks of the sample accepted four edges ago reach the decision now
        peaks_dec = peak_pipe[3];
        for (int k = 0; k < NUM_SEQ; k++) begin
            if (peaks_dec[k]) begin
                hits = hits + 1;
                idx  = nid2_t'(k);
            end
        end
        exp_result.valid = 1'b0;
        if (hits == 1 && mode == SEARCH) begin
            exp_result.valid = 1'b1;
            exp_result.nid2  = idx;
        end
        if (hits == 1 && mode == FIND && idx == req) begin
            exp_result.valid = 1'b1;
            exp_result.nid2  = req;
        end
        // acceptance uses the enable left by the previous edge
        if (v && model_en) begin
            model_win = {model_win[PSS_LEN-2:0], s};
            for (int k = 0; k < NUM_SEQ; k++) begin
                metric         = corr_metric(model_win, k);
                peaks_new[k]   = (metric >= int'(PEAK_THRESHOLD)) &&
                                 (prev_metric[k] < int'(PEAK_THRESHOLD));
                prev_metric[k] = metric;
            end
        end
        model_en     = (mode == SEARCH) || (mode == FIND);
        peak_pipe[3] = peak_pipe[2];
        peak_pipe[2] = peak_pipe[1];
        peak_pipe[1] = peak_pipe[0];
        peak_pipe[0] = peaks_new;
    end
endfunction

`endif

// ==== test/tb_pss_detector.sv ====
`timescale 1ns/1ps

module tb_pss_detector;

    import pss_sig_pkg::*;
    import pss_ctrl_pkg::*;

    `include "tb_pss_model.svh"

    localparam int CLK_HALF     = 5;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS     = 12;
    localparam int TAIL_LEN     = 20;
    localparam int STREAM_LEN   = 2 * PSS_LEN + TAIL_LEN;
    localparam int DRAIN_LEN    = 6;

    // every sample may be followed by one idle gap, then the pipeline drains
    localparam int ROW_BUDGET  = 2 * STREAM_LEN + DRAIN_LEN;
    localparam int CYCLE_LIMIT = RESET_CYCLES + 4 + NUM_ROWS * ROW_BUDGET;

    // mode, requested, sequence, amplitude, noise, gaps, expected pulses, expected nid2
    localparam stim_row_t STIM_TABLE [NUM_ROWS] = '{
        '{SEARCH, 2'd0, 2'd0, 8'd40,  8'd0,  1'b0, 2'd1, 2'd0},
        '{SEARCH, 2'd0, 2'd1, 8'd40,  8'd0,  1'b0, 2'd1, 2'd1},
        '{SEARCH, 2'd0, 2'd2, 8'd40,  8'd0,  1'b0, 2'd1, 2'd2},
        '{FIND,   2'd2, 2'd2, 8'd40,  8'd0,  1'b0, 2'd1, 2'd2},
        '{FIND,   2'd1, 2'd0, 8'd40,  8'd0,  1'b0, 2'd0, 2'd0},
        '{PAUSE,  2'd0, 2'd1, 8'd40,  8'd0,  1'b0, 2'd0, 2'd0},
        '{SEARCH, 2'd0, 2'd1, 8'd40,  8'd0,  1'b0, 2'd1, 2'd1},
        '{SEARCH, 2'd0, 2'd0, 8'd30,  8'd0,  1'b0, 2'd0, 2'd0},
        '{SEARCH, 2'd0, 2'd2, 8'd127, 8'd0,  1'b0, 2'd3, 2'd0},
        '{SEARCH, 2'd0, 2'd0, 8'd60,  8'd40, 1'b1, 2'd3, 2'd0},
        '{FIND,   2'd1, 2'd1, 8'd60,  8'd40, 1'b1, 2'd3, 2'd0},
        '{SEARCH, 2'd0, 2'd3, 8'd0,   8'd60, 1'b1, 2'd3, 2'd0}
    };

    logic         clk_i;
    logic         reset_ni;
    iq_sample_t   sample_i;
    logic         sample_valid_i;
    detect_mode_t mode_i;
    nid2_t        requested_nid2_i;
    nid2_result_t result_o;

    int    errors;
    int    checks;
    int    row_hits;
    nid2_t last_nid2;
    int    cycle_cnt;

    pss_detector i_pss_detector (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .sample_i         (sample_i),
        .sample_valid_i   (sample_valid_i),
        .mode_i           (mode_i),
        .requested_nid2_i (requested_nid2_i),
        .result_o         (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_result(nid2_result_t expected, nid2_result_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t result_o: expected valid=%b nid2=%0d, got valid=%b nid2=%0d",
                     $time, expected.valid, expected.nid2, actual.valid, actual.nid2);
        end
    endtask

    task automatic check_nid2(nid2_t expected, nid2_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t result_o.nid2: expected %0d, got %0d",
                     $time, expected, actual);
        end
    endtask

    task automatic check_hits(int row_idx, int expected, int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[ERROR] %0t result_o.valid pulses in row %0d: expected %0d, got %0d",
                     $time, row_idx, expected, actual);
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    // outputs are read at the falling edge, then the next inputs are driven
    task automatic clock_step(iq_sample_t s, logic v);
        @(negedge clk_i);
        model_edge(reset_ni, sample_i, sample_valid_i, mode_i, requested_nid2_i);
        check_result(exp_result, result_o);
        if (result_o.valid) begin
            row_hits++;
            last_nid2 = result_o.nid2;
        end
        sample_i       = s;
        sample_valid_i = v;
    endtask

    task automatic check_quiet(int cycles);
        for (int c = 0; c < cycles; c++) begin
            clock_step('0, 1'b0);
            checks++;
            if (result_o.valid !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t result_o.valid: expected 0, got %b",
                         $time, result_o.valid);
            end
        end
    endtask

    // noise, then the sequence oldest tap first, then more noise
    task automatic run_row(stim_row_t row, int row_idx);
        iq_sample_t  s;
        int          re_v;
        int          im_v;
        int          tap_sign;
        logic [31:0] gap;
        row_hits         = 0;
        mode_i           = row.mode;
        requested_nid2_i = row.req;
        for (int n = 0; n < STREAM_LEN; n++) begin
            re_v = noise_val(int'(row.noise));
            im_v = noise_val(int'(row.noise));
            if (row.seq != 2'd3 && n >= PSS_LEN && n < 2 * PSS_LEN) begin
                tap_sign = PSS_TAPS[row.seq][n - PSS_LEN] ? 1 : -1;
                re_v     = re_v + tap_sign * int'(row.amp);
                im_v     = im_v + tap_sign * int'(row.amp);
            end
            s.re = SAMPLE_DW'(re_v);
            s.im = SAMPLE_DW'(im_v);
            clock_step(s, 1'b1);
            if (row.rand_gap) begin
                gap = lfsr_bits(1);
                if (gap[0]) begin
                    clock_step('0, 1'b0);
                end
            end
        end
        if (row.exp_hits == 2'd0) begin
            check_quiet(DRAIN_LEN);
        end else begin
            repeat (DRAIN_LEN) clock_step('0, 1'b0);
        end
        if (row.exp_hits != 2'd3) begin
            check_hits(row_idx, int'(row.exp_hits), row_hits);
        end
        if (row.exp_hits == 2'd1 && row_hits == 1) begin
            check_nid2(row.exp_nid2, last_nid2);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        errors           = 0;
        checks           = 0;
        row_hits         = 0;
        last_nid2        = '0;
        lfsr_state       = 32'h89e3c7af;
        reset_ni         = 1'b0;
        sample_i         = '0;
        sample_valid_i   = 1'b0;
        mode_i           = SEARCH;
        requested_nid2_i = '0;
        repeat (RESET_CYCLES) clock_step('0, 1'b0);
        reset_ni = 1'b1;
        check_quiet(4);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(STIM_TABLE[r], r);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+test
src/pss_sig_pkg.sv
src/pss_ctrl_pkg.sv
src/pss_sample_window.sv
src/pss_correlator_lane.sv
src/pss_nid2_decider.sv
src/pss_detector.sv
test/tb_pss_detector.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compiles the PSS detector testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module tb_pss_detector \
    -f build.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
